/* source/base_decoder.sv */
module base_decoder (
    input decode_pkg::instr_word_type instr,
    output decode_pkg::decoder_out_type result
);

    logic [decode_pkg::xlen-1:0] imm_i;
    logic [decode_pkg::xlen-1:0] imm_s;
    logic [decode_pkg::xlen-1:0] imm_b;
    logic [decode_pkg::xlen-1:0] imm_u;
    logic [decode_pkg::xlen-1:0] imm_j;
    logic alt;

    function automatic decode_pkg::alu_op_type alu_from_funct3(
        input logic [2:0] funct3,
        input logic alt_op
    );
        case (funct3)
            3'b000: return alt_op ? decode_pkg::alu_sub : decode_pkg::alu_add;
            3'b001: return decode_pkg::alu_sll;
            3'b010: return decode_pkg::alu_slt;
            3'b011: return decode_pkg::alu_sltu;
            3'b100: return decode_pkg::alu_xor;
            3'b101: return alt_op ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            3'b110: return decode_pkg::alu_or;
            default: return decode_pkg::alu_and;
        endcase
    endfunction

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign alt = (instr.base.funct7 == decode_pkg::funct7_alt);

    always_comb begin
        result = '0;
        result.alu_op = decode_pkg::alu_add;
        result.bcu_op = decode_pkg::bcu_none;
        result.lsu_op = decode_pkg::lsu_none;

        case (instr.base.opcode)
            decode_pkg::opcode_lui: begin
                {result.wren, result.lui, result.valid} = 3'b111;
                result.imm = imm_u;
            end
            decode_pkg::opcode_auipc: begin
                {result.wren, result.auipc, result.valid} = 3'b111;
                result.imm = imm_u;
            end
            decode_pkg::opcode_jal: begin
                {result.wren, result.jal, result.valid} = 3'b111;
                result.imm = imm_j;
            end
            decode_pkg::opcode_jalr: begin
                {result.wren, result.rden1, result.jalr} = 3'b111;
                result.imm = imm_i;
                result.valid = (instr.base.funct3 == 3'b000);
            end
            decode_pkg::opcode_branch: begin
                {result.rden1, result.rden2, result.branch} = 3'b111;
                result.imm = imm_b;
                result.valid = 1;
                case (instr.base.funct3)
                    3'b000: result.bcu_op = decode_pkg::bcu_beq;
                    3'b001: result.bcu_op = decode_pkg::bcu_bne;
                    3'b100: result.bcu_op = decode_pkg::bcu_blt;
                    3'b101: result.bcu_op = decode_pkg::bcu_bge;
                    3'b110: result.bcu_op = decode_pkg::bcu_bltu;
                    3'b111: result.bcu_op = decode_pkg::bcu_bgeu;
                    default: result.valid = 0;
                endcase
            end
            decode_pkg::opcode_load: begin
                {result.wren, result.rden1, result.load} = 3'b111;
                result.imm = imm_i;
                result.valid = 1;
                case (instr.base.funct3)
                    3'b000: result.lsu_op = decode_pkg::lsu_lb;
                    3'b001: result.lsu_op = decode_pkg::lsu_lh;
                    3'b010: result.lsu_op = decode_pkg::lsu_lw;
                    3'b100: result.lsu_op = decode_pkg::lsu_lbu;
                    3'b101: result.lsu_op = decode_pkg::lsu_lhu;
                    default: result.valid = 0;
                endcase
            end
            decode_pkg::opcode_store: begin
                {result.rden1, result.rden2, result.store} = 3'b111;
                result.imm = imm_s;
                result.valid = 1;
                case (instr.base.funct3)
                    3'b000: result.lsu_op = decode_pkg::lsu_sb;
                    3'b001: result.lsu_op = decode_pkg::lsu_sh;
                    3'b010: result.lsu_op = decode_pkg::lsu_sw;
                    default: result.valid = 0;
                endcase
            end
            decode_pkg::opcode_op_imm: begin
                {result.wren, result.rden1} = 2'b11;
                result.imm = imm_i;
                // only shifts constrain funct7, and only srai may set it.
                result.alu_op = alu_from_funct3(instr.base.funct3, alt);
                case (instr.base.funct3)
                    3'b001: result.valid = (instr.base.funct7 == 7'b0);
                    3'b101: result.valid = (instr.base.funct7 == 7'b0) || alt;
                    default: begin
                        result.valid = 1;
                        result.alu_op = alu_from_funct3(instr.base.funct3, 1'b0);
                    end
                endcase
            end
            decode_pkg::opcode_op: begin
                {result.wren, result.rden1, result.rden2} = 3'b111;
                result.alu_op = alu_from_funct3(instr.base.funct3, alt);
                result.valid = (instr.base.funct7 == 7'b0) ||
                    (alt && (instr.base.funct3 == 3'b000 || instr.base.funct3 == 3'b101));
            end
            decode_pkg::opcode_system: begin
                if (instr[31:7] == 25'b0) begin
                    {result.ecall, result.valid} = 2'b11;
                end else if (instr[31:20] == 12'h001 && instr[19:7] == 13'b0) begin
                    {result.ebreak, result.valid} = 2'b11;
                end
            end
            default: result.valid = 0;
        endcase

        // unused address fields read as zero.
        result.waddr = result.wren ? instr.base.rd : decode_pkg::reg_zero;
        result.raddr1 = result.rden1 ? instr.base.rs1 : decode_pkg::reg_zero;
        result.raddr2 = result.rden2 ? instr.base.rs2 : decode_pkg::reg_zero;
    end

endmodule

/* source/compress_decoder.sv */
module compress_decoder (
    input decode_pkg::instr_word_type instr,
    output decode_pkg::decoder_out_type result
);

    logic [decode_pkg::xlen-1:0] imm_ci;
    logic [decode_pkg::xlen-1:0] imm_cj;
    logic high_zero;
    logic low_zero;

    // six bit immediate of c.li and c.addi.
    assign imm_ci = {{26{instr.compress.b12}}, instr.compress.b12, instr.compress.low};

    assign imm_cj = {{20{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6], instr[7],
                     instr[2], instr[11], instr[5:3], 1'b0};

    assign high_zero = (instr.compress.high == decode_pkg::reg_zero);
    assign low_zero = (instr.compress.low == decode_pkg::reg_zero);

    always_comb begin
        result = '0;
        result.alu_op = decode_pkg::alu_add;
        result.bcu_op = decode_pkg::bcu_none;
        result.lsu_op = decode_pkg::lsu_none;

        if (instr.compress.quadrant == decode_pkg::quadrant_c1) begin
            case (instr.compress.funct3)
                decode_pkg::cfunct3_addi: begin // addi rd, rd, imm.
                    {result.wren, result.rden1, result.valid} = 3'b111;
                    result.waddr = instr.compress.high;
                    result.raddr1 = instr.compress.high;
                    result.imm = imm_ci;
                end
                decode_pkg::cfunct3_li: begin   // addi rd, x0, imm.
                    {result.wren, result.rden1, result.valid} = 3'b111;
                    result.waddr = instr.compress.high;
                    result.imm = imm_ci;
                end
                decode_pkg::cfunct3_j: begin    // jal x0, offset.
                    {result.wren, result.jal, result.valid} = 3'b111;
                    result.imm = imm_cj;
                end
                default: result.valid = 0;
            endcase
        end else if (instr.compress.quadrant == decode_pkg::quadrant_c2 &&
                     instr.compress.funct3 == decode_pkg::cfunct3_cr) begin
            if (!low_zero) begin
                // mv is add rd, x0, rs2. add is add rd, rd, rs2.
                {result.wren, result.rden1, result.rden2, result.valid} = 4'b1111;
                result.waddr = instr.compress.high;
                result.raddr1 = instr.compress.b12 ? instr.compress.high : decode_pkg::reg_zero;
                result.raddr2 = instr.compress.low;
            end else if (!high_zero) begin
                // jr links to x0, jalr to x1.
                {result.wren, result.rden1, result.jalr, result.valid} = 4'b1111;
                result.waddr = instr.compress.b12 ? decode_pkg::reg_ra : decode_pkg::reg_zero;
                result.raddr1 = instr.compress.high;
            end
        end
    end

endmodule

/* source/decode_pkg.sv */
package decode_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_bits = 5;

    // base opcodes.
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_auipc = 7'b0010111;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_jalr = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [6:0] funct7_alt = 7'b0100000; // sub and sra.

    localparam logic [1:0] quadrant_c1 = 2'b01;
    localparam logic [1:0] quadrant_c2 = 2'b10;
    localparam logic [1:0] quadrant_base = 2'b11; // not compressed.

    localparam logic [2:0] cfunct3_addi = 3'b000;
    localparam logic [2:0] cfunct3_li = 3'b010;
    localparam logic [2:0] cfunct3_j = 3'b101;
    localparam logic [2:0] cfunct3_cr = 3'b100; // jr, mv, jalr, add.

    localparam logic [reg_addr_bits-1:0] reg_zero = 5'd0;
    localparam logic [reg_addr_bits-1:0] reg_ra = 5'd1;
    localparam logic [reg_addr_bits-1:0] reg_t0 = 5'd5; // alternate link.

    localparam logic [3:0] except_illegal_instruction = 4'd2;
    localparam logic [3:0] except_breakpoint = 4'd3;
    localparam logic [3:0] except_env_call_mach = 4'd11;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_type;

    typedef enum logic [2:0] {
        bcu_none, bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
    } bcu_op_type;

    typedef enum logic [3:0] {
        lsu_none, lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
    } lsu_op_type;

    typedef struct packed {
        logic [6:0] funct7;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_addr_bits-1:0] rd;
        logic [6:0] opcode;
    } base_instr_type;

    // compressed word sits in the low half.
    typedef struct packed {
        logic [15:0] upper;
        logic [2:0] funct3;
        logic b12;
        logic [4:0] high;  // rd or rs1.
        logic [4:0] low;   // rs2.
        logic [1:0] quadrant;
    } compress_instr_type;

    typedef union packed {
        base_instr_type base;
        compress_instr_type compress;
    } instr_word_type;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_word_type instr;
        logic taken;
        logic valid;
    } fetch_type;

    typedef struct packed {
        logic jump;
        logic [xlen-1:0] address;
        logic load;
        logic [reg_addr_bits-1:0] waddr;
        logic stall;
    } execute_type;

    typedef struct packed {
        logic [xlen-1:0] imm;
        logic wren;
        logic rden1;
        logic rden2;
        logic [reg_addr_bits-1:0] waddr;
        logic [reg_addr_bits-1:0] raddr1;
        logic [reg_addr_bits-1:0] raddr2;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic ecall;
        logic ebreak;
        alu_op_type alu_op;
        bcu_op_type bcu_op;
        lsu_op_type lsu_op;
        logic valid;
    } decoder_out_type;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [xlen-1:0] imm;
        logic wren;
        logic rden1;
        logic rden2;
        logic [reg_addr_bits-1:0] waddr;
        logic [reg_addr_bits-1:0] raddr1;
        logic [reg_addr_bits-1:0] raddr2;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic ecall;
        logic ebreak;
        alu_op_type alu_op;
        bcu_op_type bcu_op;
        lsu_op_type lsu_op;
        logic valid;
        logic taken;
        logic return_push;
        logic return_pop;
        logic jump_uncond;
        logic jump_rest;
        logic exception;
        logic [3:0] ecause;
        logic [xlen-1:0] etval;
    } decode_out_type;

    localparam decode_out_type init_decode_out = '0;

endpackage

/* source/decode_stage.sv */
module decode_stage (
    input logic clock,
    input logic reset,
    input decode_pkg::fetch_type fetch,
    input decode_pkg::execute_type execute,
    input logic flush,
    output decode_pkg::instr_word_type instr,
    input decode_pkg::decoder_out_type base_result,
    input decode_pkg::decoder_out_type compress_result,
    output logic stall,
    output logic clear,
    output decode_pkg::decode_out_type y,
    output decode_pkg::decode_out_type q
);

    decode_pkg::decoder_out_type dec;
    decode_pkg::decode_out_type v;
    decode_pkg::decode_out_type r;
    logic [decode_pkg::xlen-1:0] step;
    logic link_waddr;
    logic link_raddr1;
    logic hazard;
    logic mispredict;

    assign instr = fetch.instr;

    always_comb begin
        dec = compress_result.valid ? compress_result : base_result;
        step = (fetch.instr.compress.quadrant == decode_pkg::quadrant_base) ? 4 : 2;

        v = decode_pkg::init_decode_out;
        v.pc = fetch.pc;
        v.npc = fetch.pc + step;
        v.taken = fetch.taken;
        v.imm = dec.imm;
        v.wren = dec.wren;
        v.rden1 = dec.rden1;
        v.rden2 = dec.rden2;
        v.waddr = dec.waddr;
        v.raddr1 = dec.raddr1;
        v.raddr2 = dec.raddr2;
        v.lui = dec.lui;
        v.auipc = dec.auipc;
        v.jal = dec.jal;
        v.jalr = dec.jalr;
        v.branch = dec.branch;
        v.load = dec.load;
        v.store = dec.store;
        v.ecall = dec.ecall;
        v.ebreak = dec.ebreak;
        v.alu_op = dec.alu_op;
        v.bcu_op = dec.bcu_op;
        v.lsu_op = dec.lsu_op;
        v.valid = dec.valid;

        // return address stack hints, x1 and x5 are links.
        link_waddr = (dec.waddr == decode_pkg::reg_ra) || (dec.waddr == decode_pkg::reg_t0);
        link_raddr1 = (dec.raddr1 == decode_pkg::reg_ra) || (dec.raddr1 == decode_pkg::reg_t0);

        if (v.jal) begin
            if (link_waddr) begin
                v.return_push = 1;
            end else if (dec.waddr == decode_pkg::reg_zero) begin
                v.jump_uncond = 1;
            end else begin
                v.jump_rest = 1;
            end
        end

        if (v.jalr) begin
            if (!link_waddr && link_raddr1) begin
                v.return_pop = 1;
            end else if (link_waddr && !link_raddr1) begin
                v.return_push = 1;
            end else if (link_waddr && link_raddr1) begin
                v.return_push = 1;
                v.return_pop = (dec.waddr != dec.raddr1); // coroutine swap.
            end else begin
                v.jump_rest = 1;
            end
        end

        if (!v.valid) begin
            v.exception = 1;
            v.ecause = decode_pkg::except_illegal_instruction;
            v.etval = fetch.instr;
        end else if (v.ebreak) begin
            v.exception = 1;
            v.ecause = decode_pkg::except_breakpoint;
            v.etval = fetch.instr;
        end else if (v.ecall) begin
            v.exception = 1;
            v.ecause = decode_pkg::except_env_call_mach;
            v.etval = fetch.instr;
        end

        // load-use against the instruction in execute.
        hazard = fetch.valid && execute.load &&
            ((v.rden1 && execute.waddr == v.raddr1) || (v.rden2 && execute.waddr == v.raddr2));

        mispredict = (execute.jump != fetch.taken) ||
            (execute.jump && fetch.taken && execute.address != fetch.pc);
        clear = flush || mispredict;
        stall = hazard && !clear;

        if (hazard || execute.stall || clear || !fetch.valid) begin
            {v.wren, v.lui, v.auipc, v.jal, v.jalr, v.branch} = '0;
            {v.load, v.store, v.ecall, v.ebreak, v.valid, v.taken} = '0;
            {v.return_push, v.return_pop, v.jump_uncond, v.jump_rest, v.exception} = '0;
        end

        y = v;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            r <= decode_pkg::init_decode_out;
        end else begin
            r <= v;
        end
    end

    assign q = r;

endmodule

/* source/decode_top.sv */
module decode_top (
    input logic clock,
    input logic reset,
    input decode_pkg::fetch_type fetch,
    input decode_pkg::execute_type execute,
    input logic flush,
    output logic stall,
    output logic clear,
    output decode_pkg::decode_out_type y,
    output decode_pkg::decode_out_type q
);

    decode_pkg::instr_word_type instr;
    decode_pkg::decoder_out_type base_result;
    decode_pkg::decoder_out_type compress_result;

    base_decoder i_base_decoder (
        .instr(instr),
        .result(base_result)
    );

    compress_decoder i_compress_decoder (
        .instr(instr),
        .result(compress_result)
    );

    // both decoders see the same word, the stage picks one.
    decode_stage i_decode_stage (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .execute(execute),
        .flush(flush),
        .instr(instr),
        .base_result(base_result),
        .compress_result(compress_result),
        .stall(stall),
        .clear(clear),
        .y(y),
        .q(q)
    );

endmodule

/* testbench/decode_assert.sv */
module decode_assert (
    input logic clock,
    input logic reset,
    input decode_pkg::fetch_type fetch,
    input logic stall,
    input logic clear,
    input decode_pkg::decode_out_type q
);
    timeunit 1ns;
    timeprecision 100ps;

    // q only turns valid one edge after a valid fetch out of reset.
    property bubble_until_input;
        @(posedge clock) disable iff (!reset)
            (!$past(reset) || !$past(fetch.valid)) |-> !q.valid;
    endproperty

    // a stalled or cleared cycle leaves a bubble in the register.
    property hold_leaves_bubble;
        @(posedge clock) disable iff (!reset)
            (stall || clear) |=> (!q.valid && !q.exception);
    endproperty

    property illegal_keeps_word;
        @(posedge clock) disable iff (!reset)
            (q.exception && q.ecause == decode_pkg::except_illegal_instruction) |->
                (q.etval == $past(fetch.instr));
    endproperty

    assert property (bubble_until_input) else $error("q valid without a registered fetch");
    assert property (hold_leaves_bubble) else $error("q not a bubble after stall or clear");
    assert property (illegal_keeps_word) else $error("illegal etval differs from fetched word");

endmodule

/* testbench/decode_model.svh */
`ifndef decode_model_svh
`define decode_model_svh

// alt is set for the funct7 encoding of sub and sra.
function automatic decode_pkg::alu_op_type alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0: return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
        3'd1: return decode_pkg::alu_sll;
        3'd2: return decode_pkg::alu_slt;
        3'd3: return decode_pkg::alu_sltu;
        3'd4: return decode_pkg::alu_xor;
        3'd5: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
        3'd6: return decode_pkg::alu_or;
        default: return decode_pkg::alu_and;
    endcase
endfunction

task automatic decode_base_word(input logic [31:0] w, inout decode_pkg::decode_out_type d);
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] i_imm;
    f3 = w[14:12];
    f7 = w[31:25];
    i_imm = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
        decode_pkg::opcode_lui: begin
            {d.wren, d.lui, d.valid} = 3'b111;
            d.imm = {w[31:12], 12'b0};
        end
        decode_pkg::opcode_auipc: begin
            {d.wren, d.auipc, d.valid} = 3'b111;
            d.imm = {w[31:12], 12'b0};
        end
        decode_pkg::opcode_jal: begin
            {d.wren, d.jal, d.valid} = 3'b111;
            d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        decode_pkg::opcode_jalr: begin
            {d.wren, d.rden1, d.jalr} = 3'b111;
            d.imm = i_imm;
            d.valid = (f3 == 3'd0);
        end
        decode_pkg::opcode_branch: begin
            {d.rden1, d.rden2, d.branch} = 3'b111;
            d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            d.valid = (f3[2:1] != 2'b01);
            case (f3)
                3'd0: d.bcu_op = decode_pkg::bcu_beq;
                3'd1: d.bcu_op = decode_pkg::bcu_bne;
                3'd4: d.bcu_op = decode_pkg::bcu_blt;
                3'd5: d.bcu_op = decode_pkg::bcu_bge;
                3'd6: d.bcu_op = decode_pkg::bcu_bltu;
                3'd7: d.bcu_op = decode_pkg::bcu_bgeu;
                default: d.bcu_op = decode_pkg::bcu_none;
            endcase
        end
        decode_pkg::opcode_load: begin
            {d.wren, d.rden1, d.load} = 3'b111;
            d.imm = i_imm;
            d.valid = (f3 != 3'd3 && f3 < 3'd6);
            case (f3)
                3'd0: d.lsu_op = decode_pkg::lsu_lb;
                3'd1: d.lsu_op = decode_pkg::lsu_lh;
                3'd2: d.lsu_op = decode_pkg::lsu_lw;
                3'd4: d.lsu_op = decode_pkg::lsu_lbu;
                3'd5: d.lsu_op = decode_pkg::lsu_lhu;
                default: d.lsu_op = decode_pkg::lsu_none;
            endcase
        end
        decode_pkg::opcode_store: begin
            {d.rden1, d.rden2, d.store} = 3'b111;
            d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            d.valid = (f3 < 3'd3);
            if (f3 == 3'd0) d.lsu_op = decode_pkg::lsu_sb;
            if (f3 == 3'd1) d.lsu_op = decode_pkg::lsu_sh;
            if (f3 == 3'd2) d.lsu_op = decode_pkg::lsu_sw;
        end
        decode_pkg::opcode_op_imm: begin
            {d.wren, d.rden1} = 2'b11;
            d.imm = i_imm;
            d.alu_op = alu_for(f3, f3 == 3'd5 && f7 == decode_pkg::funct7_alt);
            if (f3 == 3'd1) d.valid = (f7 == 7'd0);
            else if (f3 == 3'd5) d.valid = (f7 == 7'd0 || f7 == decode_pkg::funct7_alt);
            else d.valid = 1;
        end
        decode_pkg::opcode_op: begin
            {d.wren, d.rden1, d.rden2} = 3'b111;
            d.alu_op = alu_for(f3, f7 == decode_pkg::funct7_alt);
            d.valid = (f7 == 7'd0) ||
                (f7 == decode_pkg::funct7_alt && (f3 == 3'd0 || f3 == 3'd5));
        end
        decode_pkg::opcode_system: begin
            d.ecall = (w[31:7] == 25'h0);
            d.ebreak = (w[31:7] == 25'h2000); // imm 1, all other fields zero.
            d.valid = d.ecall || d.ebreak;
        end
        default: d.valid = 0;
    endcase
    d.waddr = d.wren ? w[11:7] : 5'd0;
    d.raddr1 = d.rden1 ? w[19:15] : 5'd0;
    d.raddr2 = d.rden2 ? w[24:20] : 5'd0;
endtask

task automatic decode_compressed_word(input logic [31:0] w, inout decode_pkg::decode_out_type d);
    logic [31:0] ci_imm;
    ci_imm = {{26{w[12]}}, w[12], w[6:2]};
    case ({w[15:13], w[1:0]})
        5'b000_01: begin // c.addi.
            {d.wren, d.rden1, d.valid} = 3'b111;
            d.waddr = w[11:7];
            d.raddr1 = w[11:7];
            d.imm = ci_imm;
        end
        5'b010_01: begin // c.li reads x0.
            {d.wren, d.rden1, d.valid} = 3'b111;
            d.waddr = w[11:7];
            d.imm = ci_imm;
        end
        5'b101_01: begin
            {d.wren, d.jal, d.valid} = 3'b111;
            d.imm = {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
        end
        5'b100_10: begin
            if (w[6:2] != 5'd0) begin
                {d.wren, d.rden1, d.rden2, d.valid} = 4'b1111;
                d.waddr = w[11:7];
                d.raddr1 = w[12] ? w[11:7] : 5'd0;
                d.raddr2 = w[6:2];
            end else if (w[11:7] != 5'd0) begin
                {d.wren, d.rden1, d.jalr, d.valid} = 4'b1111;
                d.waddr = {4'd0, w[12]};
                d.raddr1 = w[11:7];
            end
        end
        default: d.valid = 0; // base decoder sees no opcode here either.
    endcase
endtask

task automatic predict_stage(
    input decode_pkg::fetch_type f,
    input decode_pkg::execute_type e,
    input logic fl,
    output decode_pkg::decode_out_type d,
    output logic st,
    output logic cl
);
    logic [31:0] w;
    logic rd_link;
    logic rs_link;
    logic hazard;
    w = f.instr;
    d = '0;
    if (w[1:0] == 2'b11) begin
        decode_base_word(w, d);
    end else begin
        decode_compressed_word(w, d);
    end
    d.pc = f.pc;
    d.npc = f.pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
    d.taken = f.taken;

    rd_link = (d.waddr == 5'd1 || d.waddr == 5'd5);
    rs_link = (d.raddr1 == 5'd1 || d.raddr1 == 5'd5);
    if (d.jal) begin
        d.return_push = rd_link;
        d.jump_uncond = (d.waddr == 5'd0);
        d.jump_rest = !rd_link && d.waddr != 5'd0;
    end
    if (d.jalr) begin
        d.return_push = rd_link;
        d.return_pop = rs_link && (!rd_link || d.waddr != d.raddr1);
        d.jump_rest = !rd_link && !rs_link;
    end

    if (!d.valid || d.ebreak || d.ecall) begin
        d.exception = 1;
        d.etval = w;
        if (!d.valid) d.ecause = decode_pkg::except_illegal_instruction;
        else if (d.ebreak) d.ecause = decode_pkg::except_breakpoint;
        else d.ecause = decode_pkg::except_env_call_mach;
    end

    hazard = f.valid && e.load &&
        ((d.rden1 && e.waddr == d.raddr1) || (d.rden2 && e.waddr == d.raddr2));
    cl = fl || (e.jump != f.taken) || (e.jump && e.address != f.pc);
    st = hazard && !cl;
    if (hazard || e.stall || cl || !f.valid) begin
        {d.wren, d.lui, d.auipc, d.jal, d.jalr, d.branch, d.load, d.store} = '0;
        {d.ecall, d.ebreak, d.valid, d.taken, d.exception} = '0;
        {d.return_push, d.return_pop, d.jump_uncond, d.jump_rest} = '0;
    end
endtask

`endif

/* testbench/decode_tb.sv */
module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int stimulus_cycles = 2000;
    localparam int cycle_limit = 3000; // stimulus plus reset and margin.

    logic clock;
    logic reset;
    decode_pkg::fetch_type fetch;
    decode_pkg::execute_type execute;
    logic flush;
    logic stall;
    logic clear;
    decode_pkg::decode_out_type y;
    decode_pkg::decode_out_type q;

    decode_pkg::decode_out_type expect_y;
    decode_pkg::decode_out_type expect_q;
    logic expect_stall;
    logic expect_clear;
    int checks;
    int errors;

    `include "decode_model.svh"

    decode_top i_dut (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .execute(execute),
        .flush(flush),
        .stall(stall),
        .clear(clear),
        .y(y),
        .q(q)
    );

    bind decode_stage decode_assert i_decode_assert (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .stall(stall),
        .clear(clear),
        .q(q)
    );

    initial begin
        clock = 0;
        forever #20 clock = ~clock;
    end

    initial begin
        for (int n = 0; n < cycle_limit; n++) begin
            @(posedge clock);
        end
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    // x0, x1 and x5 come up often so the link rules get exercised.
    function automatic logic [4:0] pick_reg();
        case ($urandom_range(3))
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd5;
            default: return 5'($urandom_range(31));
        endcase
    endfunction

    function automatic logic [31:0] pick_word();
        logic [31:0] r;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        r = $urandom();
        rd = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3 = r[14:12];
        f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? decode_pkg::funct7_alt : 7'd0;
        case ($urandom_range(17))
            0: return {r[31:12], rd, decode_pkg::opcode_lui};
            1: return {r[31:12], rd, decode_pkg::opcode_auipc};
            2: return {r[31:12], rd, decode_pkg::opcode_jal};
            3: return {r[31:20], rs1, 3'd0, rd, decode_pkg::opcode_jalr};
            4: return {r[31:25], rs2, rs1, (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3,
                       r[11:7], decode_pkg::opcode_branch};
            5: return {r[31:20], rs1, (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3, rd,
                       decode_pkg::opcode_load};
            6: return {r[31:25], rs2, rs1, 1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0],
                       r[11:7], decode_pkg::opcode_store};
            7: return {(f3[1:0] == 2'b01) ? f7 : r[31:25], r[24:20], rs1, f3, rd,
                       decode_pkg::opcode_op_imm};
            8: return {f7, rs2, rs1, f3, rd, decode_pkg::opcode_op};
            9: return 32'h0000_0073; // ecall.
            10: return 32'h0010_0073; // ebreak.
            11: return {r[31:16], 3'b010, r[12], rd, r[6:2], 2'b01};
            12: return {r[31:16], 3'b000, r[12], rd, r[6:2], 2'b01};
            13: return {r[31:16], 3'b101, r[12:2], 2'b01};
            14: return {r[31:16], 3'b100, r[12], rd, (rs2 == 5'd0) ? 5'd5 : rs2, 2'b10};
            default: return {r[31:16], 3'b100, r[12], (rs1 == 5'd0) ? 5'd1 : rs1, 5'd0, 2'b10};
        endcase
    endfunction

    task automatic draw_fetch();
        if ($urandom_range(3) == 0) begin
            fetch.instr = $urandom(); // mostly illegal.
        end else begin
            fetch.instr = pick_word();
        end
        fetch.pc = $urandom() & 32'hffff_fffe;
        fetch.taken = ($urandom_range(7) == 0);
        fetch.valid = ($urandom_range(15) != 0);
    endtask

    task automatic draw_execute();
        logic [31:0] w;
        w = fetch.instr;
        execute.stall = ($urandom_range(9) == 0);
        execute.load = ($urandom_range(3) == 0);
        case ($urandom_range(4))
            0: execute.waddr = w[19:15];
            1: execute.waddr = w[24:20];
            2: execute.waddr = w[11:7];
            3: execute.waddr = w[6:2];
            default: execute.waddr = 5'($urandom_range(31));
        endcase
        execute.jump = fetch.taken;
        execute.address = fetch.pc;
        if ($urandom_range(15) == 0) begin
            execute.jump = !fetch.taken;
        end else if ($urandom_range(15) == 0) begin
            execute.jump = 1;
            execute.address = fetch.pc + 32'd4;
        end
        flush = ($urandom_range(31) == 0);
    endtask

    task automatic compare_outputs();
        checks++;
        if (y !== expect_y) begin
            errors++;
            $display("[ERROR] %0t ns y: got %h expected %h", $time, y, expect_y);
        end
        if (q !== expect_q) begin
            errors++;
            $display("[ERROR] %0t ns q: got %h expected %h", $time, q, expect_q);
        end
        if (stall !== expect_stall) begin
            errors++;
            $display("[ERROR] %0t ns stall: got %b expected %b", $time, stall, expect_stall);
        end
        if (clear !== expect_clear) begin
            errors++;
            $display("[ERROR] %0t ns clear: got %b expected %b", $time, clear, expect_clear);
        end
    endtask

    initial begin
        logic hold;
        void'($urandom(32'hcea0_18bb));
        checks = 0;
        errors = 0;
        hold = 0;
        reset = 0;
        flush = 0;
        fetch = '0;
        execute = '0;
        repeat (9) @(posedge clock);
        @(negedge clock);
        if (q !== decode_pkg::init_decode_out) begin
            errors++;
            $display("[ERROR] %0t ns q: got %h expected %h", $time, q,
                     decode_pkg::init_decode_out);
        end
        @(posedge clock);
        #2;
        reset = 1;
        predict_stage(fetch, execute, flush, expect_q, expect_stall, expect_clear);

        for (int n = 0; n < stimulus_cycles; n++) begin
            @(posedge clock);
            #2;
            if (!hold) begin
                draw_fetch();
            end
            draw_execute();
            predict_stage(fetch, execute, flush, expect_y, expect_stall, expect_clear);
            @(negedge clock);
            compare_outputs();
            hold = expect_stall || execute.stall; // fetch presents the same word again.
            expect_q = expect_y;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
source/decode_pkg.sv
source/base_decoder.sv
source/compress_decoder.sv
source/decode_stage.sv
source/decode_top.sv
testbench/decode_assert.sv
testbench/decode_tb.sv
